/* compile.f */
logic/mem_bridge_pkg.sv
logic/async_fifo.sv
logic/bridge_sequencer.sv
logic/read_beat_assembler.sv
logic/fpga_mem_bridge.sv
verification/fpga_mem_model.sv
verification/fpga_mem_bridge_tb.sv

/* logic/async_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module async_fifo #(
    parameter int WIDTH     = 32,
    parameter int ADDR_BITS = 4
) (
    // write side
    input  wire              wclk,
    input  wire              wrst,
    input  wire              push,
    input  wire  [WIDTH-1:0] wdata,
    output logic             full,

    // read side
    input  wire              rclk,
    input  wire              rrst,
    input  wire              pop,
    output logic [WIDTH-1:0] rdata,
    output logic             empty
);

    localparam int DEPTH = 1 << ADDR_BITS;

    // top two gray bits inverted when the writer is a full lap ahead
    localparam logic [ADDR_BITS:0] FULL_MASK = 3 << (ADDR_BITS - 1);

    logic [WIDTH-1:0] mem [DEPTH];

    // pointers carry one wrap bit above the address
    logic [ADDR_BITS:0] wbin;
    logic [ADDR_BITS:0] wgray;
    logic [ADDR_BITS:0] wbin_next;
    logic [ADDR_BITS:0] wgray_next;
    logic [ADDR_BITS:0] rbin;
    logic [ADDR_BITS:0] rgray;
    logic [ADDR_BITS:0] rbin_next;
    logic [ADDR_BITS:0] rgray_next;

    // synchronizer stages
    logic [ADDR_BITS:0] rgray_w1;
    logic [ADDR_BITS:0] rgray_w2;
    logic [ADDR_BITS:0] wgray_r1;
    logic [ADDR_BITS:0] wgray_r2;

    logic do_push;
    logic do_pop;

    // overflow and underflow requests are dropped here
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign wbin_next  = wbin + (ADDR_BITS + 1)'(do_push);
    assign wgray_next = (wbin_next >> 1) ^ wbin_next;
    assign rbin_next  = rbin + (ADDR_BITS + 1)'(do_pop);
    assign rgray_next = (rbin_next >> 1) ^ rbin_next;

    always_ff @(posedge wclk) begin
        if (do_push) begin
            mem[wbin[ADDR_BITS-1:0]] <= wdata;
        end
    end

    // show-ahead, head word visible without a pop
    assign rdata = mem[rbin[ADDR_BITS-1:0]];

    always_ff @(posedge wclk) begin
        if (wrst) begin
            wbin     <= '0;
            wgray    <= '0;
            full     <= 1'b0;
            rgray_w1 <= '0;
            rgray_w2 <= '0;
        end else begin
            wbin     <= wbin_next;
            wgray    <= wgray_next;
            // compare against the reader pointer two wclk edges old
            full     <= (wgray_next == (rgray_w2 ^ FULL_MASK));
            rgray_w1 <= rgray;
            rgray_w2 <= rgray_w1;
        end
    end

    always_ff @(posedge rclk) begin
        if (rrst) begin
            rbin     <= '0;
            rgray    <= '0;
            empty    <= 1'b1;
            wgray_r1 <= '0;
            wgray_r2 <= '0;
        end else begin
            rbin     <= rbin_next;
            rgray    <= rgray_next;
            // empty when caught up with the synchronized writer
            empty    <= (rgray_next == wgray_r2);
            wgray_r1 <= wgray;
            wgray_r2 <= wgray_r1;
        end
    end

endmodule

`default_nettype wire

/* logic/bridge_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module bridge_sequencer import mem_bridge_pkg::*; (
    input  wire              clk,
    input  wire              rst,

    // cache side
    input  wire cache_req_t  bmem_req,
    output logic             bmem_ready,
    output logic [ADDR_W-1:0] bmem_raddr,
    output logic             wdata_taken,
    output logic             wdata_hi,

    // command fifo write port
    output logic             cmd_push,
    output cmd_word_t        cmd_data,
    input  wire              cmd_full,

    // response fifo read port
    output logic             resp_pop,
    input  wire              resp_empty,

    // beat assembler strobes
    output logic             word_pop,
    output logic             burst_start
);

    // one spare bit so the read count can sit at the burst length
    localparam int CNT_W = $clog2(WORDS_PER_BURST) + 1;

    typedef enum logic [2:0] {
        st_idle,
        st_send_raddr,
        st_read_words,
        st_send_waddr,
        st_write_words,
        st_await_ack,
        st_await_release
    } state_t;

    state_t state;
    state_t state_next;

    logic [CNT_W-1:0]  cnt;
    logic              cnt_clr;
    logic              cnt_inc;
    logic              addr_load;
    logic [ADDR_W-1:0] addr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            cnt   <= '0;
        end else begin
            state <= state_next;
            if (cnt_clr) begin
                cnt <= '0;
            end else if (cnt_inc) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // request address, captured on accept
    always_ff @(posedge clk) begin
        if (addr_load) begin
            addr_q <= bmem_req.addr;
        end
    end

    assign bmem_raddr = addr_q;
    // even count is the low half of the beat
    assign wdata_hi   = cnt[0];

    always_comb begin
        state_next       = state;
        bmem_ready       = 1'b0;
        wdata_taken      = 1'b0;
        cmd_push         = 1'b0;
        cmd_data.is_write = 1'b0;
        cmd_data.payload = addr_q;
        resp_pop         = 1'b0;
        burst_start      = 1'b0;
        cnt_clr          = 1'b0;
        cnt_inc          = 1'b0;
        addr_load        = 1'b0;

        case (state)
            st_idle: begin
                bmem_ready = 1'b1;
                addr_load  = bmem_req.read || bmem_req.write;
                // read wins over write
                if (bmem_req.read) begin
                    state_next = st_send_raddr;
                end else if (bmem_req.write) begin
                    state_next = st_send_waddr;
                end
            end
            st_send_raddr: begin
                cmd_push = !cmd_full;
                if (!cmd_full) begin
                    // assembler restarts on the low half
                    burst_start = 1'b1;
                    cnt_clr     = 1'b1;
                    state_next  = st_read_words;
                end
            end
            st_read_words: begin
                if (cnt == CNT_W'(WORDS_PER_BURST)) begin
                    // last beat valid shows this cycle
                    state_next = st_idle;
                end else begin
                    resp_pop = !resp_empty;
                    cnt_inc  = !resp_empty;
                end
            end
            st_send_waddr: begin
                cmd_push          = !cmd_full;
                cmd_data.is_write = 1'b1;
                if (!cmd_full) begin
                    cnt_clr    = 1'b1;
                    state_next = st_write_words;
                end
            end
            st_write_words: begin
                cmd_push          = !cmd_full;
                cmd_data.is_write = 1'b1;
                cmd_data.payload  = cnt[0] ? bmem_req.wdata[WORD_W +: WORD_W]
                                           : bmem_req.wdata[0 +: WORD_W];
                wdata_taken       = !cmd_full;
                cnt_inc           = !cmd_full;
                if (!cmd_full && cnt == CNT_W'(WORDS_PER_BURST - 1)) begin
                    state_next = st_await_ack;
                end
            end
            st_await_ack: begin
                // any word back from the fpga counts as the ack
                resp_pop   = !resp_empty;
                bmem_ready = !resp_empty;
                if (!resp_empty) begin
                    state_next = st_await_release;
                end
            end
            st_await_release: begin
                if (!bmem_req.write) begin
                    state_next = st_idle;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    // assembler only sees read pops
    assign word_pop = resp_pop && (state == st_read_words);

endmodule

`default_nettype wire

/* logic/fpga_mem_bridge.sv */
`timescale 1ns/10ps
`default_nettype none

module fpga_mem_bridge import mem_bridge_pkg::*; #(
    parameter int FIFO_ADDR_BITS = 4
) (
    input  wire               clk,
    input  wire               fpga_clk,
    input  wire               rst,

    // cache side, clk domain
    input  wire cache_req_t   bmem_req,
    output logic              bmem_ready,
    output logic [ADDR_W-1:0] bmem_raddr,
    output beat_t             bmem_rdata,
    output logic              bmem_rvalid,
    output logic              wdata_taken,
    output logic              wdata_hi,

    // fpga side, fpga_clk domain
    input  wire               cmd_pop,
    output cmd_word_t         cmd_word,
    output logic              cmd_empty,
    input  wire               resp_push,
    input  wire word_t        resp_word,
    output logic              resp_full
);

    cmd_word_t cmd_data;
    logic      cmd_push;
    logic      cmd_full;
    word_t     resp_rdata;
    logic      resp_pop;
    logic      resp_empty;
    logic      word_pop;
    logic      burst_start;

    // cpu to fpga, addresses and write data
    async_fifo #(
        .WIDTH     ($bits(cmd_word_t)),
        .ADDR_BITS (FIFO_ADDR_BITS)
    ) cmd_fifo (
        .wclk  (clk),
        .wrst  (rst),
        .push  (cmd_push),
        .wdata (cmd_data),
        .full  (cmd_full),
        .rclk  (fpga_clk),
        .rrst  (rst),
        .pop   (cmd_pop),
        .rdata (cmd_word),
        .empty (cmd_empty)
    );

    // fpga to cpu, read words and write acks
    async_fifo #(
        .WIDTH     ($bits(word_t)),
        .ADDR_BITS (FIFO_ADDR_BITS)
    ) resp_fifo (
        .wclk  (fpga_clk),
        .wrst  (rst),
        .push  (resp_push),
        .wdata (resp_word),
        .full  (resp_full),
        .rclk  (clk),
        .rrst  (rst),
        .pop   (resp_pop),
        .rdata (resp_rdata),
        .empty (resp_empty)
    );

    bridge_sequencer sequencer (
        .clk         (clk),
        .rst         (rst),
        .bmem_req    (bmem_req),
        .bmem_ready  (bmem_ready),
        .bmem_raddr  (bmem_raddr),
        .wdata_taken (wdata_taken),
        .wdata_hi    (wdata_hi),
        .cmd_push    (cmd_push),
        .cmd_data    (cmd_data),
        .cmd_full    (cmd_full),
        .resp_pop    (resp_pop),
        .resp_empty  (resp_empty),
        .word_pop    (word_pop),
        .burst_start (burst_start)
    );

    // takes the fifo head directly
    read_beat_assembler assembler (
        .clk         (clk),
        .rst         (rst),
        .burst_start (burst_start),
        .word_pop    (word_pop),
        .resp_word   (resp_rdata),
        .bmem_rdata  (bmem_rdata),
        .bmem_rvalid (bmem_rvalid)
    );

endmodule

`default_nettype wire

/* logic/mem_bridge_pkg.sv */
`default_nettype none

package mem_bridge_pkg;

    // fifo data word and cache address
    localparam int WORD_W = 32;
    localparam int ADDR_W = 32;

    // one cache beat carries two fifo words
    localparam int WORDS_PER_BEAT = 2;
    localparam int BEAT_W = WORD_W * WORDS_PER_BEAT;

    // cache bursts are four beats, so eight words cross the fifo
    localparam int BEATS_PER_BURST = 4;
    localparam int WORDS_PER_BURST = WORDS_PER_BEAT * BEATS_PER_BURST;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [BEAT_W-1:0] beat_t;

    // command fifo entry, address or write data
    typedef struct packed {
        logic  is_write;
        word_t payload;
    } cmd_word_t;

    // request bundle as the cache drives it
    typedef struct packed {
        logic              read;
        logic              write;
        logic [ADDR_W-1:0] addr;
        beat_t             wdata;
    } cache_req_t;

endpackage

`default_nettype wire

/* logic/read_beat_assembler.sv */
`timescale 1ns/10ps
`default_nettype none

module read_beat_assembler import mem_bridge_pkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  wire        burst_start,
    input  wire        word_pop,
    input  wire word_t resp_word,
    output beat_t      bmem_rdata,
    output logic       bmem_rvalid
);

    // high when the next popped word is the upper half
    logic  half;
    word_t low_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            half        <= 1'b0;
            bmem_rvalid <= 1'b0;
        end else begin
            bmem_rvalid <= word_pop && half;
            if (burst_start) begin
                half <= 1'b0;
            end else if (word_pop) begin
                half <= !half;
            end
        end
    end

    // low word waits here for its partner
    always_ff @(posedge clk) begin
        if (word_pop && !half) begin
            low_q <= resp_word;
        end
    end

    always_ff @(posedge clk) begin
        if (word_pop && half) begin
            bmem_rdata <= {resp_word, low_q};
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build with verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module fpga_mem_bridge_tb \
    -f compile.f &&
./obj_dir/Vfpga_mem_bridge_tb | tee /dev/stderr | grep -q "ALL CHECKS PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* verification/fpga_mem_bridge_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module fpga_mem_bridge_tb import mem_bridge_pkg::*; ();

    // five bursts take well under a thousand cycles
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int IDLE_GAP = 3;

    logic              clk;
    logic              fpga_clk;
    logic              rst;
    cache_req_t        bmem_req;
    logic              bmem_ready;
    logic [ADDR_W-1:0] bmem_raddr;
    beat_t             bmem_rdata;
    logic              bmem_rvalid;
    logic              wdata_taken;
    logic              wdata_hi;
    logic              cmd_pop;
    cmd_word_t         cmd_word;
    logic              cmd_empty;
    logic              resp_push;
    word_t             resp_word;
    logic              resp_full;
    logic              order_error;

    // expected traffic on both sides
    beat_t             exp_beats [$];
    cmd_word_t         exp_cmds [$];
    // written beats keyed by the word address of their low half
    beat_t             written [logic [ADDR_W-1:0]];
    beat_t             wbeats [BEATS_PER_BURST];

    logic              reading = 1'b0;
    logic              writing = 1'b0;
    logic [ADDR_W-1:0] cur_addr = '0;
    int                taken_count = 0;
    int                cycles = 0;
    integer            seed = 68;

    fpga_mem_bridge #(
        .FIFO_ADDR_BITS (2)
    ) dut0 (
        .clk         (clk),
        .fpga_clk    (fpga_clk),
        .rst         (rst),
        .bmem_req    (bmem_req),
        .bmem_ready  (bmem_ready),
        .bmem_raddr  (bmem_raddr),
        .bmem_rdata  (bmem_rdata),
        .bmem_rvalid (bmem_rvalid),
        .wdata_taken (wdata_taken),
        .wdata_hi    (wdata_hi),
        .cmd_pop     (cmd_pop),
        .cmd_word    (cmd_word),
        .cmd_empty   (cmd_empty),
        .resp_push   (resp_push),
        .resp_word   (resp_word),
        .resp_full   (resp_full)
    );

    fpga_mem_model mem_model (
        .fpga_clk    (fpga_clk),
        .rst         (rst),
        .cmd_word    (cmd_word),
        .cmd_empty   (cmd_empty),
        .cmd_pop     (cmd_pop),
        .resp_push   (resp_push),
        .resp_word   (resp_word),
        .resp_full   (resp_full),
        .order_error (order_error)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = !clk;
    end

    // slower clock whose rising edges never meet a clk edge
    initial begin
        fpga_clk = 1'b0;
        forever #65 fpga_clk = !fpga_clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string msg);
        abort_run($sformatf("Fail at %0t ns: %s", $time, msg));
    endtask

    function automatic cmd_word_t make_cmd(input logic is_write, input word_t payload);
        cmd_word_t c;
        c.is_write = is_write;
        c.payload  = payload;
        return c;
    endfunction

    // written data if any, otherwise the address pattern of the model
    function automatic beat_t expected_beat(input logic [ADDR_W-1:0] addr, input int k);
        logic [ADDR_W-1:0] low;
        low = addr + ADDR_W'(2 * k);
        if (written.exists(low)) begin
            return written[low];
        end
        return {low + ADDR_W'(1), low};
    endfunction

    // cache side checks
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT_CYCLES) begin
            abort_run("timeout: the bursts did not finish within the cycle limit");
        end
        if (!rst) begin
            assert (!(reading && bmem_ready))
                else report_mismatch("bmem_ready high during a read burst");
            // ack only once all halves went out
            assert (!(writing && bmem_ready) || taken_count == WORDS_PER_BURST)
                else report_mismatch("bmem_ready before the write data was sent");
            if (bmem_rvalid) begin
                assert (reading && exp_beats.size() > 0)
                    else abort_run("bmem_rvalid pulsed outside a read burst");
                assert (bmem_raddr == cur_addr)
                    else report_mismatch($sformatf("raddr %h, expected %h",
                                                   bmem_raddr, cur_addr));
                assert (bmem_rdata == exp_beats[0])
                    else report_mismatch($sformatf("beat %h, expected %h",
                                                   bmem_rdata, exp_beats[0]));
                void'(exp_beats.pop_front());
            end
            if (wdata_taken) begin
                assert (writing && taken_count < WORDS_PER_BURST)
                    else abort_run("wdata_taken pulsed outside a write burst");
                assert (wdata_hi == taken_count[0])
                    else report_mismatch("wdata_hi out of sequence");
                // low half first for each beat
                exp_cmds.push_back(make_cmd(1'b1, taken_count[0]
                    ? wbeats[taken_count / 2][WORD_W +: WORD_W]
                    : wbeats[taken_count / 2][0 +: WORD_W]));
                taken_count = taken_count + 1;
            end
        end
    end

    // fpga side checks
    always @(posedge fpga_clk) begin
        assert (!order_error)
            else abort_run("memory model saw a command out of order");
        if (cmd_pop && !cmd_empty) begin
            assert (exp_cmds.size() > 0)
                else abort_run("command word popped when none was expected");
            assert (cmd_word == exp_cmds[0])
                else report_mismatch($sformatf("command %h, expected %h",
                                               cmd_word, exp_cmds[0]));
            void'(exp_cmds.pop_front());
        end
    end

    // hold the request until the bridge takes it
    task automatic issue_request(input logic is_write, input logic [ADDR_W-1:0] addr);
        bmem_req.read  = !is_write;
        bmem_req.write = is_write;
        bmem_req.addr  = addr;
        do begin
            @(posedge clk);
        end while (!bmem_ready);
        #5;
        cur_addr = addr;
        exp_cmds.push_back(make_cmd(is_write, addr));
    endtask

    // back in idle and staying there
    task automatic settle_idle();
        do begin
            @(posedge clk);
        end while (!bmem_ready);
        repeat (IDLE_GAP) begin
            @(posedge clk);
            assert (bmem_ready && !bmem_rvalid && !wdata_taken && cmd_empty)
                else report_mismatch("bridge not idle between bursts");
        end
        #5;
    endtask

    task automatic read_burst(input logic [ADDR_W-1:0] addr);
        int beats = 0;
        for (int k = 0; k < BEATS_PER_BURST; k++) begin
            exp_beats.push_back(expected_beat(addr, k));
        end
        issue_request(1'b0, addr);
        bmem_req.read = 1'b0;
        reading = 1'b1;
        while (beats < BEATS_PER_BURST) begin
            @(posedge clk);
            if (bmem_rvalid) begin
                beats = beats + 1;
            end
        end
        #5;
        reading = 1'b0;
        // idle one cycle after the last beat
        @(posedge clk);
        assert (bmem_ready) else report_mismatch("bmem_ready low after the last beat");
        settle_idle();
    endtask

    task automatic write_burst(input logic [ADDR_W-1:0] addr);
        int beat = 0;
        for (int k = 0; k < BEATS_PER_BURST; k++) begin
            wbeats[k] = {$random(seed), $random(seed)};
        end
        bmem_req.wdata = wbeats[0];
        issue_request(1'b1, addr);
        taken_count = 0;
        writing = 1'b1;
        // next beat after the high half goes
        do begin
            @(posedge clk);
            if (wdata_taken && wdata_hi) begin
                beat = beat + 1;
                #5;
                bmem_req.wdata = (beat < BEATS_PER_BURST) ? wbeats[beat] : '0;
            end
        end while (!bmem_ready);
        for (int k = 0; k < BEATS_PER_BURST; k++) begin
            written[addr + ADDR_W'(2 * k)] = wbeats[k];
        end
        // bridge must wait while write stays high
        repeat (IDLE_GAP) begin
            @(posedge clk);
            assert (!bmem_ready && !wdata_taken)
                else report_mismatch("bridge moved on before write dropped");
        end
        #5;
        bmem_req.write = 1'b0;
        writing = 1'b0;
        settle_idle();
    endtask

    initial begin
        rst      = 1'b1;
        bmem_req = '0;
        repeat (10) @(posedge clk);
        #5;
        rst = 1'b0;
        @(posedge clk);
        assert (bmem_ready && !bmem_rvalid && !wdata_taken && cmd_empty && !resp_full)
            else report_mismatch("bridge not idle after reset");
        #5;
        read_burst(32'h0000_1000);
        write_burst(32'h0000_2000);
        read_burst(32'h0000_2000);
        write_burst(32'h0000_3040);
        read_burst(32'h0000_3040);
        if (exp_cmds.size() == 0 && exp_beats.size() == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            abort_run("expected traffic never arrived");
        end
    end

endmodule

`default_nettype wire

/* verification/fpga_mem_model.sv */
`timescale 1ns/10ps
`default_nettype none

module fpga_mem_model import mem_bridge_pkg::*; (
    input  wire            fpga_clk,
    input  wire            rst,
    input  wire cmd_word_t cmd_word,
    input  wire            cmd_empty,
    output logic           cmd_pop,
    output logic           resp_push,
    output word_t          resp_word,
    input  wire            resp_full,
    output logic           order_error
);

    // waiting for a command, taking write data, streaming a read, sending the ack
    typedef enum {m_cmd, m_wdata, m_rdata, m_ack} mode_t;

    mode_t  mode;
    int     cnt;
    word_t  base;
    word_t  store [word_t];
    integer seed;
    logic   stall;

    // unwritten words read back as their own address
    function automatic word_t read_word(input word_t addr);
        if (store.exists(addr)) begin
            return store[addr];
        end
        return addr;
    endfunction

    initial begin
        seed        = 68;
        cmd_pop     = 1'b0;
        resp_push   = 1'b0;
        resp_word   = '0;
        order_error = 1'b0;
        mode        = m_cmd;
        cnt         = 0;
        base        = '0;
    end

    always @(posedge fpga_clk) begin
        if (rst) begin
            mode = m_cmd;
            cnt  = 0;
        end else begin
            if (cmd_pop && !cmd_empty) begin
                case (mode)
                    m_cmd: begin
                        base = cmd_word.payload;
                        cnt  = 0;
                        mode = cmd_word.is_write ? m_wdata : m_rdata;
                    end
                    m_wdata: begin
                        // an address in the middle of write data
                        if (!cmd_word.is_write) begin
                            order_error = 1'b1;
                        end
                        store[base + word_t'(cnt)] = cmd_word.payload;
                        cnt = cnt + 1;
                        if (cnt == WORDS_PER_BURST) begin
                            mode = m_ack;
                        end
                    end
                endcase
            end
            // accepted push advances the stream or ends the ack
            if (resp_push && !resp_full) begin
                cnt = cnt + 1;
                if (mode == m_ack || cnt == WORDS_PER_BURST) begin
                    mode = m_cmd;
                end
            end
        end
        #5;
        stall     = ($random(seed) & 3) == 0;
        cmd_pop   = !rst && (mode == m_cmd || mode == m_wdata) && !stall;
        resp_push = !rst && (mode == m_rdata || mode == m_ack);
        resp_word = (mode == m_ack) ? base : read_word(base + word_t'(cnt));
    end

endmodule

`default_nettype wire
